//--- logic/exmem_pkg.sv
package exmem_pkg;

    //////////////////////////////////////////////////
    // widths and limits
    //////////////////////////////////////////////////

    localparam int xlen           = 32;
    localparam int rob_idx_w      = 4;
    localparam int reg_idx_w      = 5;
    localparam int shamt_w        = $clog2(xlen);
    localparam int timeout_cycles = 16;                          // cycles a bus phase may wait.
    localparam int timer_w        = $clog2(timeout_cycles + 1);
    localparam logic [xlen-1:0] pc_step = 4;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_slt,
        op_beq,
        op_bne,
        op_load,
        op_store
    } op_e;

    typedef enum logic [2:0] {
        exc_none,
        exc_misaligned,
        exc_bus_timeout
    } exc_e;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release,
        st_retire
    } mem_state_e;

    //////////////////////////////////////////////////
    // stage records
    //////////////////////////////////////////////////

    typedef struct packed {
        op_e                  op;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      a;
        logic [xlen-1:0]      b;
        logic [xlen-1:0]      imm;
        logic [xlen-1:0]      store_data;
        logic [reg_idx_w-1:0] rd;
        logic [rob_idx_w-1:0] rob_idx;
        logic                 valid;
    } issue_t;

    typedef struct packed {
        logic                 valid;
        op_e                  op;
        logic [xlen-1:0]      alu_out;    // result, or the address for memory ops.
        logic [xlen-1:0]      store_data;
        logic [xlen-1:0]      new_pc;
        logic                 branch_taken;
        logic [reg_idx_w-1:0] rd;
        logic                 write_enable;
        logic                 mem_read;
        logic                 mem_write;
        logic [rob_idx_w-1:0] rob_idx;
        exc_e                 exc;
    } exmem_t;

    typedef struct packed {
        logic                 valid;
        logic [rob_idx_w-1:0] rob_idx;
        logic [xlen-1:0]      value;
        logic [xlen-1:0]      new_pc;
        logic                 branch_taken;
        logic [reg_idx_w-1:0] rd;
        logic                 write_enable;
        exc_e                 exc;
    } retire_t;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } bus_req_t;

endpackage

//--- logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  exmem_pkg::issue_t issue,
    output exmem_pkg::exmem_t result
);
    import exmem_pkg::*;

    logic [xlen-1:0] addr;
    logic [xlen-1:0] target;
    logic            misaligned;

    assign addr       = issue.a + issue.imm;    // effective address for loads and stores.
    assign target     = issue.pc + issue.imm;
    assign misaligned = (addr[1:0] != 2'b00);   // only word accesses exist.

    always_comb begin
        result              = '0;
        result.valid        = issue.valid;
        result.op           = issue.op;
        result.store_data   = issue.store_data;
        result.rd           = issue.rd;
        result.rob_idx      = issue.rob_idx;
        result.new_pc       = issue.pc + pc_step;
        result.write_enable = 1'b1;
        result.exc          = exc_none;

        case (issue.op)
            op_add: result.alu_out = issue.a + issue.b;
            op_sub: result.alu_out = issue.a - issue.b;
            op_and: result.alu_out = issue.a & issue.b;
            op_or:  result.alu_out = issue.a | issue.b;
            op_xor: result.alu_out = issue.a ^ issue.b;
            op_sll: result.alu_out = issue.a << issue.b[shamt_w-1:0];
            op_srl: result.alu_out = issue.a >> issue.b[shamt_w-1:0];
            op_slt: result.alu_out = xlen'($signed(issue.a) < $signed(issue.b));
            op_beq, op_bne: begin
                // the ROB decides on redirect from branch_taken and new_pc.
                result.alu_out      = target;
                result.new_pc       = target;
                result.branch_taken = (issue.op == op_beq) ? (issue.a == issue.b)
                                                           : (issue.a != issue.b);
                result.write_enable = 1'b0;
            end
            op_load: begin
                result.alu_out = addr;
                if (misaligned) begin
                    result.exc          = exc_misaligned;
                    result.write_enable = 1'b0;
                end else begin
                    result.mem_read = 1'b1;
                end
            end
            op_store: begin
                result.alu_out      = addr;
                result.write_enable = 1'b0;
                if (misaligned) begin
                    result.exc = exc_misaligned;
                end else begin
                    result.mem_write = 1'b1;
                end
            end
            default: begin
                result.write_enable = 1'b0;   // unused encodings retire as no-ops.
            end
        endcase
    end

endmodule

//--- logic/ex_mem_regs.sv
`timescale 1ns/1ps

module ex_mem_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  exmem_pkg::exmem_t d,
    output exmem_pkg::exmem_t q
);
    import exmem_pkg::*;

    logic                 load;

    logic                 valid_q;
    logic                 branch_taken_q;
    logic                 write_enable_q;
    logic                 mem_read_q;
    logic                 mem_write_q;
    exc_e                 exc_q;

    op_e                  op_q;
    logic [xlen-1:0]      alu_out_q;
    logic [xlen-1:0]      store_data_q;
    logic [xlen-1:0]      new_pc_q;
    logic [reg_idx_w-1:0] rd_q;
    logic [rob_idx_w-1:0] rob_idx_q;

    assign load = !stall;   // the stage freezes while memory is busy.

    //////////////////////////////////////////////////
    // control fields
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q        <= 1'b0;
            branch_taken_q <= 1'b0;
            write_enable_q <= 1'b0;
            mem_read_q     <= 1'b0;
            mem_write_q    <= 1'b0;
            exc_q          <= exc_none;
        end else if (load) begin
            valid_q        <= d.valid;
            branch_taken_q <= d.branch_taken;
            write_enable_q <= d.write_enable;
            mem_read_q     <= d.mem_read;
            mem_write_q    <= d.mem_write;
            exc_q          <= d.exc;
        end
    end

    //////////////////////////////////////////////////
    // payload fields
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            op_q         <= d.op;
            alu_out_q    <= d.alu_out;
            store_data_q <= d.store_data;
            new_pc_q     <= d.new_pc;
            rd_q         <= d.rd;
            rob_idx_q    <= d.rob_idx;
        end
    end

    assign q = '{valid:        valid_q,
                 op:           op_q,
                 alu_out:      alu_out_q,
                 store_data:   store_data_q,
                 new_pc:       new_pc_q,
                 branch_taken: branch_taken_q,
                 rd:           rd_q,
                 write_enable: write_enable_q,
                 mem_read:     mem_read_q,
                 mem_write:    mem_write_q,
                 rob_idx:      rob_idx_q,
                 exc:          exc_q};

    // the memory controller relies on seeing one entry for the whole access.
    hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(q))
        else $error("EX/MEM contents changed on a stalled edge.");

endmodule

//--- logic/bus_timer.sv
`timescale 1ns/1ps

module bus_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic timed_out
);
    import exmem_pkg::*;

    logic [timer_w-1:0] count;
    logic               at_limit;

    assign at_limit = (count == timer_w'(timeout_cycles));

    // counts waiting cycles of one bus phase and sticks at the limit.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;                     // each new phase starts from zero.
        end else if (!at_limit) begin
            count <= count + 1'b1;
        end
    end

    // only a running phase can time out.
    assign timed_out = run && at_limit;

endmodule

//--- logic/mem_stage_ctrl.sv
`timescale 1ns/1ps

module mem_stage_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  exmem_pkg::exmem_t   ex,
    input  logic                mem_ack,
    input  logic [31:0]         mem_rdata,
    input  logic                timed_out,
    output exmem_pkg::bus_req_t bus,
    output logic                timer_run,
    output logic                stall,
    output exmem_pkg::retire_t  retire
);
    import exmem_pkg::*;

    mem_state_e      state;
    bus_req_t        bus_q;
    retire_t         retire_q;
    logic [xlen-1:0] rdata_q;
    logic            timeout_seen;   // the request phase ran out without an ack.
    logic            mem_op;
    logic            bus_timeout;

    function automatic retire_t pack_retire(exmem_t e, logic [xlen-1:0] value,
                                            exc_e exc, logic we);
        retire_t r;
        r.valid        = 1'b1;
        r.rob_idx      = e.rob_idx;
        r.value        = value;
        r.new_pc       = e.new_pc;
        r.branch_taken = e.branch_taken;
        r.rd           = e.rd;
        r.write_enable = we;
        r.exc          = exc;
        return r;
    endfunction

    assign mem_op      = ex.valid && (ex.mem_read || ex.mem_write);
    assign bus_timeout = timeout_seen || timed_out;

    //////////////////////////////////////////////////
    // stall and timer control
    //////////////////////////////////////////////////

    always_comb begin
        unique case (state)
            st_idle:    stall = mem_op;   // raised in the cycle the access arrives.
            st_retire:  stall = 1'b0;
            default:    stall = 1'b1;
        endcase
    end

    always_comb begin
        unique case (state)
            st_req:     timer_run = !mem_ack;
            st_release: timer_run = mem_ack;
            default:    timer_run = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // four-phase handshake and retire
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            bus_q        <= '0;
            retire_q     <= '0;
            timeout_seen <= 1'b0;
        end else begin
            retire_q.valid <= 1'b0;
            unique case (state)
                st_idle: begin
                    timeout_seen <= 1'b0;
                    if (mem_op) begin
                        bus_q.req   <= 1'b1;
                        bus_q.we    <= ex.mem_write;
                        bus_q.addr  <= ex.alu_out;
                        bus_q.wdata <= ex.store_data;
                        state       <= st_req;
                    end else if (ex.valid) begin
                        retire_q <= pack_retire(ex, ex.alu_out, ex.exc, ex.write_enable);
                    end
                end
                st_req: begin
                    if (mem_ack) begin
                        bus_q.req <= 1'b0;
                        state     <= st_release;
                    end else if (timed_out) begin
                        bus_q.req    <= 1'b0;
                        timeout_seen <= 1'b1;
                        state        <= st_release;
                    end
                end
                st_release: begin
                    // wait for ack to fall unless that wait times out too.
                    if (!mem_ack || timed_out) begin
                        retire_q <= pack_retire(ex,
                            (ex.mem_read && !bus_timeout) ? rdata_q : ex.alu_out,
                            bus_timeout ? exc_bus_timeout : ex.exc,
                            ex.write_enable && !bus_timeout);
                        state    <= st_retire;
                    end
                end
                st_retire: begin
                    state <= st_idle;   // EX/MEM takes the next entry on this edge.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_req && mem_ack) begin
            rdata_q <= mem_rdata;   // read data is valid while ack is high.
        end
    end

    assign bus    = bus_q;
    assign retire = retire_q;

    // ack must have been low on the edge that raised req.
    req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus.req) |-> !$past(mem_ack))
        else $error("Bus request raised while ack was still high.");

    mem_retire_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_retire) |-> retire.valid ##1 !retire.valid)
        else $error("Memory retire was not a single-cycle pulse.");

endmodule

//--- logic/exmem_slice.sv
`timescale 1ns/1ps

module exmem_slice (
    input  logic                clk,
    input  logic                rst_n,
    input  exmem_pkg::issue_t   issue,
    output logic                ready,
    output exmem_pkg::bus_req_t bus,
    input  logic                mem_ack,
    input  logic [31:0]         mem_rdata,
    output exmem_pkg::retire_t  retire
);
    import exmem_pkg::*;

    exmem_t ex_d;        // combinational execute result.
    exmem_t ex_q;        // registered EX/MEM entry.
    logic   stall;
    logic   timer_run;
    logic   timed_out;

    //////////////////////////////////////////////////
    // execute stage
    //////////////////////////////////////////////////

    alu_unit alu_unit_inst (
        .issue  (issue),
        .result (ex_d)
    );

    ex_mem_regs ex_mem_regs_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .d     (ex_d),
        .q     (ex_q)
    );

    //////////////////////////////////////////////////
    // memory stage
    //////////////////////////////////////////////////

    bus_timer bus_timer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (timer_run),
        .timed_out (timed_out)
    );

    mem_stage_ctrl mem_stage_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex        (ex_q),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .timed_out (timed_out),
        .bus       (bus),
        .timer_run (timer_run),
        .stall     (stall),
        .retire    (retire)
    );

    // upstream may issue whenever the EX/MEM register is free to load.
    assign ready = !stall;

endmodule

//--- tb/bus_mem_model.sv
`timescale 1ns/1ps

module bus_mem_model (
    input  logic                clk,
    input  logic                rst_n,
    input  exmem_pkg::bus_req_t bus,
    input  logic                no_reply,
    output logic                ack,
    output logic [31:0]         rdata,
    output logic                violation
);
    import exmem_pkg::*;

    localparam logic [15:0] lfsr_seed   = 16'h0003;
    localparam int          drive_delay = 2;

    logic [xlen-1:0] mem [logic [xlen-1:0]];
    logic [15:0]     lfsr;
    bus_req_t        bus_last;

    // galois form of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // three bits, one step each, give an ack delay of 0 to 7 cycles.
    task automatic draw_delay(output int cycles);
        logic [2:0] d;
        d = '0;
        for (int i = 0; i < 3; i++) begin
            d    = {d[1:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        cycles = int'(d);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);
    endtask

    function automatic logic [xlen-1:0] read_word(logic [xlen-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_3c3c;    // unwritten words.
    endfunction

    //////////////////////////////////////////////////
    // responder
    //////////////////////////////////////////////////

    initial begin
        int wait_cycles;
        ack   = 1'b0;
        rdata = '0;
        lfsr  = lfsr_seed;
        forever begin
            next_cycle();
            if (rst_n && bus.req && !no_reply) begin
                draw_delay(wait_cycles);
                repeat (wait_cycles) next_cycle();
                if (bus.we) begin
                    mem[bus.addr] = bus.wdata;
                end else begin
                    rdata = read_word(bus.addr);
                end
                ack = 1'b1;
                while (bus.req) next_cycle();
                draw_delay(wait_cycles);
                repeat (wait_cycles) next_cycle();
                ack = 1'b0;
            end
        end
    end

    // sampled before the responder drives, so ack is the value the DUT saw at the edge.
    initial begin
        violation = 1'b0;
        bus_last  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && bus.req && !bus_last.req && ack) begin
                $display("bus protocol error: req rose while ack was still high.");
                violation = 1'b1;
            end
            if (rst_n && bus.req && bus_last.req && (bus.we != bus_last.we ||
                    bus.addr != bus_last.addr || bus.wdata != bus_last.wdata)) begin
                $display("bus protocol error: addr, we or wdata changed while req was high.");
                violation = 1'b1;
            end
            bus_last = bus;
        end
    end

endmodule

//--- tb/exmem_slice_tb.sv
`timescale 1ns/1ps

module exmem_slice_tb;
    import exmem_pkg::*;

    localparam int clk_period      = 40;
    localparam int drive_delay     = 2;
    localparam int reset_cycles    = 8;
    localparam int num_tests       = 6;
    localparam int test_budget_ns  = 2000;
    localparam int wait_limit      = 80;      // cycles for one handshake or retire.

    logic            clk;
    logic            rst_n;
    issue_t          issue;
    logic            ready;
    bus_req_t        bus;
    logic            mem_ack;
    logic [xlen-1:0] mem_rdata;
    retire_t         retire;
    logic            no_reply;
    logic            violation;

    int              cycle = 0;
    int              req_rises = 0;
    logic            req_last = 1'b0;
    bus_req_t        req_log [$];
    retire_t         ret_q [$];
    int              ret_cycle_q [$];
    string           test_name;

    exmem_slice exmem_slice_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .ready     (ready),
        .bus       (bus),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .retire    (retire)
    );

    bus_mem_model bus_mem_model_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .no_reply  (no_reply),
        .ack       (mem_ack),
        .rdata     (mem_rdata),
        .violation (violation)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // retires and request edges are collected mid-cycle, away from the clock edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (retire.valid) begin
                ret_q.push_back(retire);
                ret_cycle_q.push_back(cycle);
            end
            if (bus.req && !req_last) begin
                req_rises = req_rises + 1;
                req_log.push_back(bus);
            end
            req_last = bus.req;
        end
    end

    initial begin
        #(reset_cycles * clk_period + num_tests * test_budget_ns);
        $display("watchdog expired: the tests did not finish in time, the DUT looks hung.");
        fail_run();
    end

    initial begin
        @(posedge violation);
        fail_run();
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic fail_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
            fail_run();
        end
    endtask

    function automatic issue_t make_issue(op_e op, logic [xlen-1:0] pc, logic [xlen-1:0] a,
                                          logic [xlen-1:0] b, logic [xlen-1:0] imm,
                                          logic [xlen-1:0] sdata, logic [reg_idx_w-1:0] rd,
                                          logic [rob_idx_w-1:0] rob);
        issue_t i;
        i.op         = op;
        i.pc         = pc;
        i.a          = a;
        i.b          = b;
        i.imm        = imm;
        i.store_data = sdata;
        i.rd         = rd;
        i.rob_idx    = rob;
        i.valid      = 1'b1;
        return i;
    endfunction

    function automatic logic [xlen-1:0] ref_alu(op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a + ~b + 32'd1;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // held counts the edges where ready was low and the instruction had to wait.
    task automatic send(input issue_t ins, output int acc_cycle, output int held);
        logic taken;
        taken = 1'b0;
        held  = 0;
        issue = ins;
        while (!taken) begin
            if (held == wait_limit) begin
                $display("ready stayed low for %0d cycles in test %s.", wait_limit, test_name);
                fail_run();
            end else begin
                @(negedge clk);
                taken = ready;
                @(posedge clk);
                #(drive_delay);
                if (!taken) begin
                    held = held + 1;
                end
            end
        end
        acc_cycle   = cycle;
        issue.valid = 1'b0;
    endtask

    task automatic get_retire(output retire_t r, output int ret_cycle);
        int waited;
        waited = 0;
        while (ret_q.size() == 0) begin
            if (waited == wait_limit) begin
                $display("no retire came within %0d cycles in test %s.", wait_limit, test_name);
                fail_run();
            end else begin
                @(posedge clk);
                #(drive_delay);
                waited = waited + 1;
            end
        end
        r         = ret_q.pop_front();
        ret_cycle = ret_cycle_q.pop_front();
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic alu_ops();
        op_e             ops [8] = '{op_add, op_sub, op_and, op_or,
                                     op_xor, op_sll, op_srl, op_slt};
        logic [xlen-1:0] a_set [2] = '{32'h8000_00f3, 32'h0000_1234};
        logic [xlen-1:0] b_set [2] = '{32'h0000_0005, 32'hffff_fff0};
        issue_t          ins;
        retire_t         r;
        int              acc;
        int              held;
        int              rc;
        test_name = "alu_ops";
        check("ready after reset", 32'd1, 32'(ready));
        check("req after reset", 32'd0, 32'(bus.req));
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 8; i++) begin
                ins = make_issue(ops[i], 32'h1000, a_set[k], b_set[k], 32'h0, 32'h0,
                                 5'(i + 1), 4'(8 * k + i));
                send(ins, acc, held);
                get_retire(r, rc);
                check("retire cycle", 32'(acc + 1), 32'(rc));   // two cycles after issue.
                check("value", ref_alu(ops[i], a_set[k], b_set[k]), r.value);
                check("rd", 32'(ins.rd), 32'(r.rd));
                check("write_enable", 32'd1, 32'(r.write_enable));
                check("rob_idx", 32'(ins.rob_idx), 32'(r.rob_idx));
                check("exc", 32'(exc_none), 32'(r.exc));
            end
        end
    endtask

    task automatic branches();
        issue_t          ins;
        retire_t         r;
        op_e             op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] pc;
        logic            taken;
        int              acc;
        int              held;
        int              rc;
        test_name = "branches";
        a = 32'h0000_7777;
        for (int i = 0; i < 4; i++) begin
            op    = (i < 2) ? op_beq : op_bne;
            b     = (i % 2 == 0) ? a : a + 32'd1;
            pc    = 32'h0000_2000 + 32'(16 * i);
            taken = (i == 0) || (i == 3);   // beq on equal operands, bne on unequal ones.
            ins   = make_issue(op, pc, a, b, 32'hffff_ffe0, 32'h0, 5'd7, 4'(i));
            send(ins, acc, held);
            get_retire(r, rc);
            check("branch_taken", 32'(taken), 32'(r.branch_taken));
            check("new_pc", pc - 32'd32, r.new_pc);
            check("write_enable", 32'd0, 32'(r.write_enable));
            check("rob_idx", 32'(i), 32'(r.rob_idx));
        end
    endtask

    task automatic store_then_load();
        issue_t          st;
        issue_t          ld;
        retire_t         r;
        bus_req_t        seen;
        logic [xlen-1:0] data;
        int              acc;
        int              held;
        int              rc;
        test_name = "store_then_load";
        req_log.delete();
        for (int j = 0; j < 3; j++) begin
            data = 32'hcafe_f000 + 32'(j);
            st = make_issue(op_store, 32'h0, 32'h200 + 32'(8 * j), 32'h0, 32'h10, data,
                            5'd0, 4'(2 * j));
            ld = make_issue(op_load, 32'h4, 32'h208 + 32'(8 * j), 32'h0, 32'h8, 32'h0,
                            5'd9, 4'(2 * j + 1));
            send(st, acc, held);
            send(ld, acc, held);
            check("load held while store busy", 32'd1, 32'(held > 0));
            get_retire(r, rc);
            check("store rob_idx", 32'(st.rob_idx), 32'(r.rob_idx));
            check("store write_enable", 32'd0, 32'(r.write_enable));
            check("store exc", 32'(exc_none), 32'(r.exc));
            get_retire(r, rc);
            check("load rob_idx", 32'(ld.rob_idx), 32'(r.rob_idx));
            check("load value", data, r.value);
            check("load rd", 32'd9, 32'(r.rd));
            check("load write_enable", 32'd1, 32'(r.write_enable));
            check("bus requests", 32'd2, 32'(req_log.size()));
            seen = req_log.pop_front();
            check("store we", 32'd1, 32'(seen.we));
            check("store addr", 32'h210 + 32'(8 * j), seen.addr);
            check("store wdata", data, seen.wdata);
            seen = req_log.pop_front();
            check("load we", 32'd0, 32'(seen.we));
            check("load addr", 32'h210 + 32'(8 * j), seen.addr);
        end
    endtask

    task automatic misaligned_load();
        issue_t  ins;
        retire_t r;
        int      rises;
        int      acc;
        int      held;
        int      rc;
        test_name = "misaligned_load";
        rises = req_rises;
        ins = make_issue(op_load, 32'h0, 32'h300, 32'h0, 32'h2, 32'h0, 5'd4, 4'd3);
        send(ins, acc, held);
        get_retire(r, rc);
        check("retire cycle", 32'(acc + 1), 32'(rc));
        check("exc", 32'(exc_misaligned), 32'(r.exc));
        check("write_enable", 32'd0, 32'(r.write_enable));
        check("rob_idx", 32'd3, 32'(r.rob_idx));
        check("req rises", 32'(rises), 32'(req_rises));
    endtask

    task automatic bus_timeout();
        issue_t  ins;
        retire_t r;
        int      acc;
        int      held;
        int      rc;
        test_name = "bus_timeout";
        no_reply = 1'b1;
        ins = make_issue(op_load, 32'h0, 32'h400, 32'h0, 32'h0, 32'h0, 5'd11, 4'd5);
        send(ins, acc, held);
        get_retire(r, rc);
        check("exc", 32'(exc_bus_timeout), 32'(r.exc));
        check("write_enable", 32'd0, 32'(r.write_enable));
        check("rob_idx", 32'd5, 32'(r.rob_idx));
        no_reply = 1'b0;
        ins = make_issue(op_add, 32'h8, 32'd7, 32'd8, 32'h0, 32'h0, 5'd12, 4'd6);
        send(ins, acc, held);
        get_retire(r, rc);
        check("value after timeout", 32'd15, r.value);
        check("rob_idx after timeout", 32'd6, 32'(r.rob_idx));
        check("exc after timeout", 32'(exc_none), 32'(r.exc));
    endtask

    task automatic back_pressure();
        issue_t  seq [4];
        retire_t r;
        int      acc;
        int      held;
        int      rc;
        test_name = "back_pressure";
        seq[0] = make_issue(op_store, 32'h3000, 32'h500, 32'h0, 32'h0, 32'h0bad_cafe,
                            5'd0, 4'd8);
        seq[1] = make_issue(op_add, 32'h3004, 32'd100, 32'd23, 32'h0, 32'h0, 5'd1, 4'd9);
        seq[2] = make_issue(op_xor, 32'h3008, 32'hff00_ff00, 32'h0ff0_0ff0, 32'h0, 32'h0,
                            5'd2, 4'd10);
        seq[3] = make_issue(op_sub, 32'h300c, 32'd5, 32'd9, 32'h0, 32'h0, 5'd3, 4'd11);
        for (int i = 0; i < 4; i++) begin
            send(seq[i], acc, held);
            if (i == 1) begin
                check("issue held under stall", 32'd1, 32'(held > 0));
            end
        end
        for (int i = 0; i < 4; i++) begin
            get_retire(r, rc);
            check("rob_idx", 32'(seq[i].rob_idx), 32'(r.rob_idx));
            check("exc", 32'(exc_none), 32'(r.exc));
            if (i == 0) begin
                check("store write_enable", 32'd0, 32'(r.write_enable));
            end else begin
                check("value", ref_alu(seq[i].op, seq[i].a, seq[i].b), r.value);
                check("write_enable", 32'd1, 32'(r.write_enable));
            end
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        issue    = '0;
        no_reply = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        rst_n = 1'b1;
        alu_ops();
        branches();
        store_then_load();
        misaligned_load();
        bus_timeout();
        back_pressure();
        $display("Test passed");
        $finish;
    end

endmodule

//--- exmem_slice.f
logic/exmem_pkg.sv
logic/alu_unit.sv
logic/ex_mem_regs.sv
logic/bus_timer.sv
logic/mem_stage_ctrl.sv
logic/exmem_slice.sv
tb/bus_mem_model.sv
tb/exmem_slice_tb.sv

//--- Makefile
# Verilator lint and simulation for the EX/MEM slice.

VERILATOR ?= verilator
TOP       ?= exmem_slice_tb
FILELIST  ?= exmem_slice.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=
PASS_LINE ?= Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

clean:
	rm -rf $(BUILD_DIR)
